/* hdl/dcache_defines.svh */
// cache geometry macros: address, line count, index, offset and word widths
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// byte address
`define DC_ADDR_W   17

// 16 lines of one word each
`define DC_LINES    16
`define DC_INDEX_W  4

// byte inside a line
`define DC_OFFSET_W 2

`define DC_WORD_W   32

`endif

/* hdl/dcache_pkg.sv */
// data cache types: vector typedefs, enums and packed structs
`include "dcache_defines.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]   addr_t;
    typedef logic [`DC_WORD_W-1:0]   word_t;
    typedef logic [`DC_ADDR_W-`DC_INDEX_W-`DC_OFFSET_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;
    // bit 3 is the lowest address in the line
    typedef logic [`DC_WORD_W/8-1:0] lane_en_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } size_e;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } op_e;

    typedef enum logic [1:0] {
        mem_nop   = 2'd0,
        mem_read  = 2'd1,
        mem_write = 2'd2
    } mem_op_e;

    typedef enum logic [2:0] {
        idle         = 3'd0,
        fetch_first  = 3'd1,
        fetch_second = 3'd2,
        store_wait   = 3'd3,
        finish       = 3'd4
    } state_e;

    typedef struct packed {
        op_e   op;
        size_e size;
        addr_t addr;
        word_t wdata;
    } cache_req_t;

    typedef struct packed {
        mem_op_e op;
        addr_t   addr;
        size_e   size;
        word_t   wdata;
    } mem_cmd_t;

    typedef struct packed {
        index_t  first_index;
        tag_t    first_tag;
        offset_t offset;
        index_t  second_index;
        tag_t    second_tag;
        logic    first_hit;
        logic    second_hit;
        logic    load_hit;
    } lookup_t;

    typedef struct packed {
        index_t   index;
        tag_t     tag;
        lane_en_t lanes;
        word_t    data;
        logic     refill;
    } line_write_t;

endpackage

/* hdl/dcache_decode.sv */
// request decode: address split, two-line hit check, store lane mapping
`include "dcache_defines.svh"

module dcache_decode (
    input  dcache_pkg::cache_req_t  req,
    input  logic                    first_valid,
    input  logic                    second_valid,
    input  dcache_pkg::tag_t        first_tag,
    input  dcache_pkg::tag_t        second_tag,
    output dcache_pkg::lookup_t     lookup,
    output dcache_pkg::line_write_t store_first,
    output dcache_pkg::line_write_t store_second
);
    import dcache_pkg::*;

    localparam int TAG_LSB = `DC_INDEX_W + `DC_OFFSET_W;
    localparam int LANES   = `DC_WORD_W / 8;

    addr_t                   next_addr;
    logic [`DC_OFFSET_W:0]   last_offset;
    word_t                   swapped;
    lane_en_t                size_lanes;
    logic [2*`DC_WORD_W-1:0] pair_data;
    logic [2*LANES-1:0]      pair_lanes;

    // second line is simply the next word address, so index 15 wraps to 0
    assign next_addr = req.addr + addr_t'(LANES);

    always_comb begin
        lookup.first_index  = req.addr[TAG_LSB-1:`DC_OFFSET_W];
        lookup.first_tag    = req.addr[`DC_ADDR_W-1:TAG_LSB];
        lookup.offset       = req.addr[`DC_OFFSET_W-1:0];
        lookup.second_index = next_addr[TAG_LSB-1:`DC_OFFSET_W];
        lookup.second_tag   = next_addr[`DC_ADDR_W-1:TAG_LSB];
        lookup.first_hit    = first_valid && (first_tag == lookup.first_tag);
        lookup.second_hit   = second_valid && (second_tag == lookup.second_tag);

        // offset of the last byte touched; bit 2 set means the access crosses
        case (req.size)
            size_half: last_offset = {1'b0, lookup.offset} + 3'd1;
            size_word: last_offset = {1'b0, lookup.offset} + 3'd3;
            default:   last_offset = {1'b0, lookup.offset};
        endcase
        lookup.load_hit = lookup.first_hit &&
                          (!last_offset[`DC_OFFSET_W] || lookup.second_hit);
    end

    // store data into memory order, lowest address in the top byte
    always_comb begin
        swapped = {req.wdata[7:0], req.wdata[15:8], req.wdata[23:16], req.wdata[31:24]};
        case (req.size)
            size_byte: size_lanes = 4'b1000;
            size_half: size_lanes = 4'b1100;
            default:   size_lanes = 4'b1111;
        endcase
        pair_data  = {swapped, word_t'(0)} >> {lookup.offset, 3'b000};
        pair_lanes = {size_lanes, lane_en_t'(0)} >> lookup.offset;
    end

    always_comb begin
        store_first.index  = lookup.first_index;
        store_first.tag    = lookup.first_tag;
        store_first.lanes  = pair_lanes[2*LANES-1:LANES] & {LANES{lookup.first_hit}};
        store_first.data   = pair_data[2*`DC_WORD_W-1:`DC_WORD_W];
        store_first.refill = 1'b0;

        store_second.index  = lookup.second_index;
        store_second.tag    = lookup.second_tag;
        store_second.lanes  = pair_lanes[LANES-1:0] & {LANES{lookup.second_hit}};
        store_second.data   = pair_data[`DC_WORD_W-1:0];
        store_second.refill = 1'b0;
    end

endmodule

/* hdl/dcache_lines.sv */
// line storage: valid bits, tags and data words with refill and lane writes
`include "dcache_defines.svh"

module dcache_lines (
    input  logic                    clk,
    input  logic                    rst_n,
    input  dcache_pkg::index_t      first_index,
    input  dcache_pkg::index_t      second_index,
    input  logic                    store_we,
    input  dcache_pkg::line_write_t store_first,
    input  dcache_pkg::line_write_t store_second,
    input  dcache_pkg::line_write_t refill_write,
    input  logic                    refill_we,
    output logic                    first_valid,
    output logic                    second_valid,
    output dcache_pkg::tag_t        first_tag,
    output dcache_pkg::tag_t        second_tag,
    output dcache_pkg::word_t       first_data,
    output dcache_pkg::word_t       second_data
);
    import dcache_pkg::*;

    logic [`DC_LINES-1:0] valid;
    tag_t                 tag_mem  [`DC_LINES];
    word_t                data_mem [`DC_LINES];

    function automatic word_t merge_lanes(word_t old_word, word_t new_word, lane_en_t lanes);
        word_t merged;
        merged = old_word;
        for (int i = 0; i < $bits(lane_en_t); i++) begin
            if (lanes[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (refill_we && refill_write.refill) begin
            valid[refill_write.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            if (refill_write.refill) begin
                tag_mem[refill_write.index] <= refill_write.tag;
            end
            data_mem[refill_write.index] <= merge_lanes(data_mem[refill_write.index],
                                                        refill_write.data, refill_write.lanes);
        end
        // the two store halves always target different lines
        if (store_we) begin
            data_mem[store_first.index] <= merge_lanes(data_mem[store_first.index],
                                                       store_first.data, store_first.lanes);
            data_mem[store_second.index] <= merge_lanes(data_mem[store_second.index],
                                                        store_second.data, store_second.lanes);
        end
    end

    assign first_valid  = valid[first_index];
    assign second_valid = valid[second_index];
    assign first_tag    = tag_mem[first_index];
    assign second_tag   = tag_mem[second_index];
    assign first_data   = data_mem[first_index];
    assign second_data  = data_mem[second_index];

endmodule

/* hdl/dcache_execute.sv */
// request FSM: miss refills, write-through, busy/done and capture control
`include "dcache_defines.svh"

module dcache_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  dcache_pkg::cache_req_t  req,
    input  dcache_pkg::lookup_t     lookup,
    input  logic                    mem_ack,
    input  dcache_pkg::word_t       mem_rdata,
    output dcache_pkg::mem_cmd_t    mem_cmd,
    output logic                    store_we,
    output logic                    refill_we,
    output dcache_pkg::line_write_t refill_write,
    output logic                    capture,
    output logic                    capture_saved,
    output dcache_pkg::cache_req_t  saved_req,
    output dcache_pkg::index_t      miss_index,
    output logic                    busy,
    output logic                    done
);
    import dcache_pkg::*;

    localparam int TAG_LSB = `DC_INDEX_W + `DC_OFFSET_W;

    state_e state;
    logic   accept;
    addr_t  saved_next;

    function automatic addr_t line_base(addr_t a);
        return {a[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};
    endfunction

    assign accept     = (state == idle) && req_valid;
    assign saved_next = saved_req.addr + addr_t'(1 << `DC_OFFSET_W);
    assign busy       = (state != idle);

    // index from the live request so lines never depends on the lookup
    assign miss_index = (state == idle) ? req.addr[TAG_LSB-1:`DC_OFFSET_W]
                                        : saved_req.addr[TAG_LSB-1:`DC_OFFSET_W];

    assign store_we      = accept && (req.op == op_store);
    assign capture_saved = (state == finish);
    assign capture       = (accept && req.op == op_load && lookup.load_hit) || capture_saved;

    assign refill_we = mem_ack && (mem_cmd.op == mem_read) &&
                       (state == fetch_first || state == fetch_second);

    always_comb begin
        refill_write.lanes  = '1;
        refill_write.data   = mem_rdata;
        refill_write.refill = 1'b1;
        if (state == fetch_second) begin
            refill_write.index = saved_next[TAG_LSB-1:`DC_OFFSET_W];
            refill_write.tag   = saved_next[`DC_ADDR_W-1:TAG_LSB];
        end else begin
            refill_write.index = saved_req.addr[TAG_LSB-1:`DC_OFFSET_W];
            refill_write.tag   = saved_req.addr[`DC_ADDR_W-1:TAG_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            saved_req <= req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= idle;
            done    <= 1'b0;
            mem_cmd <= '{op: mem_nop, size: size_byte, default: '0};
        end else begin
            done <= 1'b0;
            case (state)
                idle: begin
                    if (accept && req.op == op_store) begin
                        state   <= store_wait;
                        mem_cmd <= '{op: mem_write, addr: req.addr, size: req.size,
                                     wdata: req.wdata};
                    end else if (accept && !lookup.load_hit) begin
                        state   <= fetch_first;
                        mem_cmd <= '{op: mem_read, addr: line_base(req.addr),
                                     size: size_word, wdata: '0};
                    end else if (accept) begin
                        done <= 1'b1;
                    end
                end
                fetch_first: begin
                    if (mem_ack) begin
                        state      <= fetch_second;
                        mem_cmd.op <= mem_nop;
                    end
                end
                fetch_second: begin
                    // one nop cycle after the first ack, then the next line
                    if (mem_cmd.op == mem_nop) begin
                        mem_cmd <= '{op: mem_read, addr: line_base(saved_next),
                                     size: size_word, wdata: '0};
                    end else if (mem_ack) begin
                        state      <= finish;
                        mem_cmd.op <= mem_nop;
                    end
                end
                store_wait: begin
                    if (mem_ack) begin
                        state      <= idle;
                        mem_cmd.op <= mem_nop;
                        done       <= 1'b1;
                    end
                end
                finish: begin
                    state <= idle;
                    done  <= 1'b1;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* hdl/dcache_result.sv */
// load result: byte extraction, reorder, sign extension and output register
`include "dcache_defines.svh"

module dcache_result (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   capture,
    input  logic                   capture_saved,
    input  dcache_pkg::cache_req_t req,
    input  dcache_pkg::cache_req_t saved_req,
    input  dcache_pkg::word_t      first_data,
    input  dcache_pkg::word_t      second_data,
    output dcache_pkg::word_t      load_data
);
    import dcache_pkg::*;

    cache_req_t              sel_req;
    offset_t                 offset;
    logic [2*`DC_WORD_W-1:0] joined;
    word_t                   raw;
    logic [7:0]              b0;
    logic [7:0]              b1;
    logic [7:0]              b2;
    logic [7:0]              b3;
    word_t                   value;

    assign sel_req = capture_saved ? saved_req : req;
    assign offset  = sel_req.addr[`DC_OFFSET_W-1:0];

    // both lines side by side, shifted so the addressed byte is on top
    always_comb begin
        joined = {first_data, second_data} << {offset, 3'b000};
        raw    = joined[2*`DC_WORD_W-1:`DC_WORD_W];
        b0     = raw[31:24];
        b1     = raw[23:16];
        b2     = raw[15:8];
        b3     = raw[7:0];
    end

    always_comb begin
        case (sel_req.size)
            size_byte: value = {{24{b0[7]}}, b0};
            size_half: value = {{16{b1[7]}}, b1, b0};
            default:   value = {b3, b2, b1, b0};
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_data <= '0;
        end else if (capture) begin
            load_data <= value;
        end
    end

endmodule

/* hdl/dcache_top.sv */
// data cache top: decode, line storage, request FSM and result register
module dcache_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  dcache_pkg::cache_req_t req,
    output logic                   busy,
    output logic                   done,
    output dcache_pkg::word_t      load_data,
    output dcache_pkg::mem_cmd_t   mem_cmd,
    input  logic                   mem_ack,
    input  dcache_pkg::word_t      mem_rdata
);
    import dcache_pkg::*;

    lookup_t     lookup;
    line_write_t store_first;
    line_write_t store_second;
    line_write_t refill_write;
    logic        store_we;
    logic        refill_we;
    logic        capture;
    logic        capture_saved;
    cache_req_t  saved_req;
    index_t      miss_index;
    index_t      second_index;
    logic        first_valid;
    logic        second_valid;
    tag_t        first_tag;
    tag_t        second_tag;
    word_t       first_data;
    word_t       second_data;

    // following line, wrapping at the last index
    assign second_index = miss_index + index_t'(1);

    dcache_decode u_decode (
        .req          (req),
        .first_valid  (first_valid),
        .second_valid (second_valid),
        .first_tag    (first_tag),
        .second_tag   (second_tag),
        .lookup       (lookup),
        .store_first  (store_first),
        .store_second (store_second)
    );

    dcache_lines u_lines (
        .clk          (clk),
        .rst_n        (rst_n),
        .first_index  (miss_index),
        .second_index (second_index),
        .store_we     (store_we),
        .store_first  (store_first),
        .store_second (store_second),
        .refill_write (refill_write),
        .refill_we    (refill_we),
        .first_valid  (first_valid),
        .second_valid (second_valid),
        .first_tag    (first_tag),
        .second_tag   (second_tag),
        .first_data   (first_data),
        .second_data  (second_data)
    );

    dcache_execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req           (req),
        .lookup        (lookup),
        .mem_ack       (mem_ack),
        .mem_rdata     (mem_rdata),
        .mem_cmd       (mem_cmd),
        .store_we      (store_we),
        .refill_we     (refill_we),
        .refill_write  (refill_write),
        .capture       (capture),
        .capture_saved (capture_saved),
        .saved_req     (saved_req),
        .miss_index    (miss_index),
        .busy          (busy),
        .done          (done)
    );

    dcache_result u_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture       (capture),
        .capture_saved (capture_saved),
        .req           (req),
        .saved_req     (saved_req),
        .first_data    (first_data),
        .second_data   (second_data),
        .load_data     (load_data)
    );

endmodule

/* sim/mem_model.sv */
// memory model: byte array behind the word port with a per-command ack delay
`include "dcache_defines.svh"

module mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dcache_pkg::mem_cmd_t mem_cmd,
    input  logic [1:0]           ack_delay,
    input  logic                 fill_we,
    input  dcache_pkg::addr_t    fill_addr,
    input  logic [7:0]           fill_byte,
    output logic                 mem_ack,
    output dcache_pkg::word_t    mem_rdata
);
    import dcache_pkg::*;

    logic [7:0] storage [2**`DC_ADDR_W];
    logic       active;
    logic [1:0] wait_left;
    logic       fire;

    function automatic int byte_count(input size_e size);
        case (size)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    // delay is latched when a command first shows up
    assign fire = active && !mem_ack && (wait_left == 2'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            wait_left <= 2'd0;
            mem_ack   <= 1'b0;
        end else if (mem_ack) begin
            active  <= 1'b0;
            mem_ack <= 1'b0;
        end else if (!active && mem_cmd.op != mem_nop) begin
            active    <= 1'b1;
            wait_left <= ack_delay;
        end else if (fire) begin
            mem_ack <= 1'b1;
        end else if (active) begin
            wait_left <= wait_left - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            storage[fill_addr] <= fill_byte;
        end
        for (int i = 0; i < 4; i++) begin
            // writes arrive lowest byte first and may cross a word
            if (fire && mem_cmd.op == mem_write && i < byte_count(mem_cmd.size)) begin
                storage[mem_cmd.addr + addr_t'(i)] <= mem_cmd.wdata[8*i +: 8];
            end
            // reads return memory order, lowest address on top
            if (fire && mem_cmd.op == mem_read) begin
                mem_rdata[31-8*i -: 8] <= storage[mem_cmd.addr + addr_t'(i)];
            end
        end
    end

endmodule

/* sim/tb_dcache.sv */
// testbench: clock, reset, LFSR requests, shadow memory, cache tag model, checks, watchdog
`include "dcache_defines.svh"

module tb_dcache;
    import dcache_pkg::*;

    localparam int PERIOD     = 4;
    localparam int NUM_REQ    = 600;
    localparam int REQ_CYCLES = 40;
    localparam int BASE       = 'h400;
    localparam int FILL_BYTES = 72;
    localparam int SHADOW     = 128;
    localparam int TIMEOUT    = (NUM_REQ * REQ_CYCLES + FILL_BYTES + 16) * PERIOD;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    cache_req_t req;
    logic       busy;
    logic       done;
    word_t      load_data;
    mem_cmd_t   mem_cmd;
    logic       mem_ack;
    word_t      mem_rdata;
    logic [1:0] ack_delay;
    logic       fill_we;
    addr_t      fill_addr;
    logic [7:0] fill_byte;

    logic [31:0] lfsr;
    logic [7:0]  shadow [SHADOW];
    // line number held at each index, -1 when empty
    int          model_line [`DC_LINES];
    mem_cmd_t    acks [$];
    logic        first_busy;
    int          wait_cycles;

    dcache_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .done      (done),
        .load_data (load_data),
        .mem_cmd   (mem_cmd),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    mem_model u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_cmd   (mem_cmd),
        .ack_delay (ack_delay),
        .fill_we   (fill_we),
        .fill_addr (fill_addr),
        .fill_byte (fill_byte),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    always #(PERIOD/2) clk = ~clk;

    // fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic int size_bytes(input size_e size);
        case (size)
            size_byte: return 1;
            size_half: return 2;
            default:   return 4;
        endcase
    endfunction

    // little-endian assembly, sign taken from the last byte loaded
    function automatic word_t expected_load(input addr_t addr, input size_e size);
        word_t      value;
        logic [7:0] top;
        int         count;
        int         off;
        count = size_bytes(size);
        off   = int'(addr) - BASE;
        value = '0;
        top   = shadow[7'(off + count - 1)];
        for (int i = 0; i < 4; i++) begin
            if (i < count) begin
                value[8*i +: 8] = shadow[7'(off + i)];
            end else begin
                value[8*i +: 8] = {8{top[7]}};
            end
        end
        return value;
    endfunction

    function automatic cache_req_t random_request();
        cache_req_t r;
        logic [1:0] size_code;
        r.op      = (random_bits(2) == 0) ? op_store : op_load;
        size_code = 2'(random_bits(2));
        r.size    = (size_code == 2'd3) ? size_word : size_e'(size_code);
        r.addr    = addr_t'(BASE + int'(random_bits(6)));
        r.wdata   = random_bits(32);
        return r;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("error %s: got 0x%h, expected 0x%h", name, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1);
        end
    endtask

    // new ack delay drawn on every falling edge
    task automatic step_cycle();
        @(negedge clk);
        ack_delay = 2'(random_bits(2));
    endtask

    // strobe one request and wait for done, logging acked memory commands
    task automatic issue(input cache_req_t r);
        logic finished;
        if (done) begin
            step_cycle();
        end
        acks.delete();
        req       = r;
        req_valid = 1'b1;
        step_cycle();
        req_valid   = 1'b0;
        first_busy  = busy;
        wait_cycles = 0;
        finished    = 1'b0;
        while (!finished) begin
            if (mem_ack) begin
                acks.push_back(mem_cmd);
            end
            if (done) begin
                finished = 1'b1;
            end else begin
                wait_cycles++;
                step_cycle();
            end
        end
    endtask

    task automatic run_load(input cache_req_t r);
        int     line;
        index_t first;
        index_t second;
        logic   crosses;
        logic   hit;
        line    = int'(r.addr) >> `DC_OFFSET_W;
        first   = index_t'(line);
        second  = index_t'(line + 1);
        crosses = (int'(r.addr[1:0]) + size_bytes(r.size)) > 4;
        hit     = (model_line[first] == line) &&
                  (!crosses || model_line[second] == line + 1);
        issue(r);
        check_value("load_data", load_data, expected_load(r.addr, r.size));
        if (hit) begin
            check_value("done latency", word_t'(wait_cycles), '0);
            check_value("busy", word_t'(first_busy), '0);
            // a command issued on the strobe edge would still be held here
            check_value("mem_cmd.op", word_t'(mem_cmd.op), word_t'(mem_nop));
        end else begin
            check_value("busy", word_t'(first_busy), 1);
            check_value("mem_cmd count", word_t'(acks.size()), 2);
            for (int i = 0; i < 2; i++) begin
                check_value("mem_cmd.op", word_t'(acks[i].op), word_t'(mem_read));
                check_value("mem_cmd.addr", word_t'(acks[i].addr), word_t'((line + i) * 4));
            end
            model_line[first]  = line;
            model_line[second] = line + 1;
        end
    endtask

    task automatic run_store(input cache_req_t r);
        int off;
        off = int'(r.addr) - BASE;
        for (int i = 0; i < size_bytes(r.size); i++) begin
            shadow[7'(off + i)] = r.wdata[8*i +: 8];
        end
        issue(r);
        check_value("busy", word_t'(first_busy), 1);
        check_value("mem_cmd count", word_t'(acks.size()), 1);
        check_value("mem_cmd.op", word_t'(acks[0].op), word_t'(mem_write));
        check_value("mem_cmd.addr", word_t'(acks[0].addr), word_t'(r.addr));
        check_value("mem_cmd.size", word_t'(acks[0].size), word_t'(r.size));
        check_value("mem_cmd.wdata", acks[0].wdata, r.wdata);
    endtask

    initial begin
        #(TIMEOUT);
        $display("*** TEST FAILED ***");
        $display("watchdog expired before all requests completed");
        $fatal(1);
    end

    initial begin
        cache_req_t r;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        ack_delay = 2'd0;
        fill_we   = 1'b0;
        fill_addr = '0;
        fill_byte = '0;
        lfsr      = 32'hd894;
        for (int i = 0; i < `DC_LINES; i++) begin
            model_line[i] = -1;
        end
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        step_cycle();
        check_value("busy", word_t'(busy), '0);
        check_value("done", word_t'(done), '0);
        check_value("mem_cmd.op", word_t'(mem_cmd.op), word_t'(mem_nop));

        // memory and shadow start from the same random bytes
        for (int i = 0; i < FILL_BYTES; i++) begin
            fill_we           = 1'b1;
            fill_addr         = addr_t'(BASE + i);
            fill_byte         = 8'(random_bits(8));
            shadow[7'(i)]     = fill_byte;
            step_cycle();
        end
        fill_we = 1'b0;

        for (int n = 0; n < NUM_REQ; n++) begin
            r = random_request();
            // cold cache, so the first load must miss
            if (n == 0) begin
                r.op = op_load;
            end
            if (r.op == op_store) begin
                run_store(r);
                if (random_bits(1) == 1) begin
                    r.op = op_load;
                    run_load(r);
                end
            end else begin
                run_load(r);
                if (random_bits(1) == 1) begin
                    run_load(r);
                end
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/dcache_decode.sv
hdl/dcache_lines.sv
hdl/dcache_execute.sv
hdl/dcache_result.sv
hdl/dcache_top.sv
sim/mem_model.sv
sim/tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the data cache testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

build_dir=obj_dir
log=sim.log

verilator --binary --timing -f tb.f --top-module tb_dcache -Mdir "$build_dir" -o tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/tb_dcache" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qF '*** TEST PASSED ***' "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
